// ==== src/AvPatternPkg.sv ====
/*
 * AvPatternPkg
 * Shared format constants, bar colours, sine table and pixel/timing structs
 * for the audio and video test-pattern source
 */
package AvPatternPkg;

    // Horizontal format in pixels, order is active, front porch, sync, back porch
    localparam int hActive = 32;
    localparam int hFrontPorch = 4;
    localparam int hSyncPulse = 4;
    localparam int hBackPorch = 8;
    localparam int hTotal = hActive + hFrontPorch + hSyncPulse + hBackPorch;

    // Vertical format in lines, same ordering as horizontal
    localparam int vActive = 6;
    localparam int vFrontPorch = 1;
    localparam int vSyncPulse = 2;
    localparam int vBackPorch = 2;
    localparam int vTotal = vActive + vFrontPorch + vSyncPulse + vBackPorch;

    // Position counter widths, sized for hTotal and vTotal
    localparam int hPosWidth = 6;
    localparam int vPosWidth = 4;

    // 75 percent bar amplitude
    localparam logic [7:0] barLevel = 8'hC0;

    // Free-running blink counter width
    localparam int blinkCounterSize = 6;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgbPixelT;

    typedef struct packed {
        logic dataEnable;
        logic hSync;
        logic vSync;
        logic [hPosWidth-1:0] hPos;
        logic [vPosWidth-1:0] vPos;
    } videoTimingT;

    typedef struct packed {
        videoTimingT timing;
        rgbPixelT pixel;
    } videoOutT;

    // Standard bar order, left to right
    localparam rgbPixelT barColors [0:7] = '{
        '{r: barLevel, g: barLevel, b: barLevel},  // white
        '{r: barLevel, g: barLevel, b: 8'h00},     // yellow
        '{r: 8'h00, g: barLevel, b: barLevel},     // cyan
        '{r: 8'h00, g: barLevel, b: 8'h00},        // green
        '{r: barLevel, g: 8'h00, b: barLevel},     // magenta
        '{r: barLevel, g: 8'h00, b: 8'h00},        // red
        '{r: 8'h00, g: 8'h00, b: barLevel},        // blue
        '{r: 8'h00, g: 8'h00, b: 8'h00}            // black
    };

    // One sine period in 16 steps, amplitude 16384
    localparam logic signed [15:0] sineTable [0:15] = '{
        16'sd0, 16'sd6270, 16'sd11585, 16'sd15137,
        16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270,
        16'sd0, -16'sd6270, -16'sd11585, -16'sd15137,
        -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270
    };

endpackage

// ==== src/VideoFormatTiming.sv ====
/*
 * VideoFormatTiming
 * Raster position counters decoded into registered sync, data-enable
 * and position for the reduced test format
 */
`timescale 1ns/1ps

module VideoFormatTiming (
    input  logic                      pixelClock,
    input  logic                      reset,
    output AvPatternPkg::videoTimingT rasterTiming
);
    import AvPatternPkg::*;

    // Current raster position
    logic [hPosWidth-1:0] hCount;
    logic [vPosWidth-1:0] vCount;

    // Wrap points
    logic lineEnd;
    logic frameEnd;

    // Decoded levels for the current position
    logic activeNext;
    logic hSyncNext;
    logic vSyncNext;

    assign lineEnd = (hCount == hPosWidth'(hTotal - 1));
    assign frameEnd = (vCount == vPosWidth'(vTotal - 1));

    // Active area sits at the start of both line and frame
    assign activeNext = (hCount < hActive) && (vCount < vActive);

    // Sync follows the front porch
    assign hSyncNext = (hCount >= hActive + hFrontPorch) &&
                       (hCount < hActive + hFrontPorch + hSyncPulse);

    // Whole lines of vertical sync
    assign vSyncNext = (vCount >= vActive + vFrontPorch) &&
                       (vCount < vActive + vFrontPorch + vSyncPulse);

    // One pixel per clock, line wrap steps the line counter
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            if (frameEnd) begin
                vCount <= '0;
            end else begin
                vCount <= vCount + 1'b1;
            end
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Decoded timing registered alongside the position it describes
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            rasterTiming <= '0;
        end else begin
            rasterTiming.dataEnable <= activeNext;
            rasterTiming.hSync <= hSyncNext;
            rasterTiming.vSync <= vSyncNext;
            rasterTiming.hPos <= hCount;
            rasterTiming.vPos <= vCount;
        end
    end

endmodule

// ==== src/ColorBarPattern.sv ====
/*
 * ColorBarPattern
 * Eight vertical colour bars, registered together with the raster
 * timing so control and pixel leave on the same cycle
 */
`timescale 1ns/1ps

module ColorBarPattern (
    input  logic                      pixelClock,
    input  logic                      reset,
    input  AvPatternPkg::videoTimingT rasterTiming,
    output AvPatternPkg::videoOutT    videoOut
);
    import AvPatternPkg::*;

    // Bar number, four pixels per bar across the active line
    logic [2:0] barIndex;

    // Colour for the incoming position
    rgbPixelT barPixel;

    assign barIndex = 3'(rasterTiming.hPos / 4);

    // Black outside active video
    always_comb begin
        if (rasterTiming.dataEnable) begin
            barPixel = barColors[barIndex];
        end else begin
            barPixel = '0;
        end
    end

    // Timing passes through unchanged, one cycle behind
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            videoOut <= '0;
        end else begin
            videoOut.timing <= rasterTiming;
            videoOut.pixel <= barPixel;
        end
    end

endmodule

// ==== src/SineTone.sv ====
/*
 * SineTone
 * Table-driven sine sample, stepped one entry per audio sample strobe
 */
`timescale 1ns/1ps

module SineTone (
    input  logic               pixelClock,
    input  logic               reset,
    input  logic               sampleEnable,
    output logic signed [15:0] toneSample
);
    import AvPatternPkg::*;

    // Position within the 16-entry period
    logic [3:0] phase;

    // Entry that the next strobe selects, wraps after 15
    logic [3:0] nextPhase;

    assign nextPhase = phase + 4'd1;

    // Phase only moves on a strobe
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            phase <= '0;
        end else if (sampleEnable) begin
            phase <= nextPhase;
        end
    end

    // Sample register, starts at sineTable[0] which is zero
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            toneSample <= sineTable[0];
        end else if (sampleEnable) begin
            toneSample <= sineTable[nextPhase];
        end
    end

endmodule

// ==== src/AudioDeltaSigmaDac.sv ====
/*
 * AudioDeltaSigmaDac
 * First-order delta-sigma modulator, one output bit per pixel clock
 */
`timescale 1ns/1ps

module AudioDeltaSigmaDac (
    input  logic               pixelClock,
    input  logic               reset,
    input  logic signed [15:0] sampleLevel,
    output logic               bitstream
);
    // Level moved to offset binary, i.e. sample plus 32768
    logic [15:0] offsetLevel;

    // Error accumulator and its next value with carry
    logic [15:0] accumulator;
    logic [16:0] accumulatorSum;

    // Flipping the sign bit adds the half-scale offset
    assign offsetLevel = {~sampleLevel[15], sampleLevel[14:0]};

    assign accumulatorSum = {1'b0, accumulator} + {1'b0, offsetLevel};

    // Carry out is the pulse, so ones density tracks offsetLevel / 65536
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            accumulator <= '0;
            bitstream <= 1'b0;
        end else begin
            accumulator <= accumulatorSum[15:0];
            bitstream <= accumulatorSum[16];
        end
    end

endmodule

// ==== src/AvTestPatterns.sv ====
/*
 * AvTestPatterns
 * Audio and video test-pattern source: colour bars, sine tone,
 * delta-sigma audio bitstream and a blink LED on one pixel clock
 */
`timescale 1ns/1ps

module AvTestPatterns (
    input  logic                   pixelClock,
    input  logic                   reset,
    input  logic                   sampleEnable,
    output AvPatternPkg::videoOutT videoOut,
    output logic signed [15:0]     toneSample,
    output logic                   deltaSigma,
    output logic                   blink
);
    import AvPatternPkg::*;

    // Raster state from the timing generator into the bar stage
    videoTimingT rasterTiming;

    // Free-running LED counter
    logic [blinkCounterSize-1:0] blinkCount;

    always_ff @(posedge pixelClock) begin
        if (reset) begin
            blinkCount <= '0;
        end else begin
            blinkCount <= blinkCount + 1'b1;
        end
    end

    // MSB toggles every half wrap of the counter
    assign blink = blinkCount[blinkCounterSize-1];

    // Video path
    VideoFormatTiming formatTiming (
        .pixelClock(pixelClock),
        .reset(reset),
        .rasterTiming(rasterTiming)
    );

    ColorBarPattern colorBars (
        .pixelClock(pixelClock),
        .reset(reset),
        .rasterTiming(rasterTiming),
        .videoOut(videoOut)
    );

    // Audio path, paced by the sample strobe
    SineTone sineTone (
        .pixelClock(pixelClock),
        .reset(reset),
        .sampleEnable(sampleEnable),
        .toneSample(toneSample)
    );

    // Modulator runs every pixel clock on the held sample
    AudioDeltaSigmaDac audioDac (
        .pixelClock(pixelClock),
        .reset(reset),
        .sampleLevel(toneSample),
        .bitstream(deltaSigma)
    );

endmodule

// ==== dv/AvTestPatterns_tb.sv ====
/*
 * AvTestPatterns_tb
 * Self-checking testbench for the audio and video test-pattern source
 * Expected colours, sine samples and strobe spacing come from the data file
 */
`timescale 1ns/1ps

module AvTestPatterns_tb;
    import AvPatternPkg::*;

    // Reference raster layout
    localparam int lineLength = 48;
    localparam int frameLines = 11;
    localparam int activePixels = 32;
    localparam int activeLines = 6;
    localparam int hSyncFirst = 36;
    localparam int hSyncLast = 39;
    localparam int vSyncFirst = 7;
    localparam int vSyncLast = 8;

    localparam int strobeCount = 20;
    localparam int releaseTimeout = 8;
    localparam int gapLimit = 1000;

    logic pixelClock;
    logic reset;
    logic sampleEnable;
    videoOutT videoOut;
    logic signed [15:0] toneSample;
    logic deltaSigma;
    logic blink;

    // Values from the data file
    rgbPixelT expectedColors [0:7];
    logic signed [15:0] expectedSamples [0:15];
    int minGap;
    int maxGap;

    // Model state
    int releasedEdges;
    logic [5:0] blinkModel;
    logic [3:0] toneIndex;
    logic signed [15:0] expectedTone;

    // Delta-sigma window between two strobes
    logic windowOpen;
    int onesCount;
    int windowLength;
    logic signed [15:0] windowTone;

    AvTestPatterns dut_i (
        .pixelClock(pixelClock),
        .reset(reset),
        .sampleEnable(sampleEnable),
        .videoOut(videoOut),
        .toneSample(toneSample),
        .deltaSigma(deltaSigma),
        .blink(blink)
    );

    always #2 pixelClock = ~pixelClock;

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkVideo(input videoOutT actual, input videoOutT expected);
        if (actual !== expected) begin
            $display("CHECK FAILED videoOut: got %h expected %h", actual, expected);
            abortRun();
        end
    endtask

    task automatic checkSample(input string name, input logic signed [15:0] actual,
                               input logic signed [15:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
            abortRun();
        end
    endtask

    // Ones count must sit within one of offsetLevel * length / 65536
    task automatic checkDensity(input int ones, input int length,
                                input logic signed [15:0] level);
        longint target;
        longint scaled;
        target = (longint'(level) + 32768) * length;
        scaled = longint'(ones) * 65536;
        if (scaled > target + 65536 || scaled < target - 65536) begin
            $display("CHECK FAILED deltaSigma ones: got %h expected %h over %0d cycles",
                     ones, target / 65536, length);
            abortRun();
        end
    endtask

    // Expected video for the Nth edge after release including the bar stage delay
    function automatic videoOutT expectedVideo(input int edgeIndex);
        videoOutT expected;
        int pixelIndex;
        int hPos;
        int vPos;
        expected = '0;
        if (edgeIndex > 0) begin
            pixelIndex = edgeIndex - 1;
            hPos = pixelIndex % lineLength;
            vPos = (pixelIndex / lineLength) % frameLines;
            expected.timing.hPos = 6'(hPos);
            expected.timing.vPos = 4'(vPos);
            expected.timing.dataEnable = (hPos < activePixels) && (vPos < activeLines);
            expected.timing.hSync = (hPos >= hSyncFirst) && (hPos <= hSyncLast);
            expected.timing.vSync = (vPos >= vSyncFirst) && (vPos <= vSyncLast);
            if (expected.timing.dataEnable) begin
                expected.pixel = expectedColors[hPos / 4];
            end
        end
        return expected;
    endfunction

    // Next non-comment line of the data file
    task automatic readDataLine(input int fd, output string text);
        string line;
        text = "";
        while (text == "") begin
            if ($fgets(line, fd) == 0) begin
                $display("Input data file ended before all values were read");
                abortRun();
            end else if (line.len() > 0 && line.getc(0) != "/" && line.getc(0) != "\n") begin
                text = line;
            end
        end
    endtask

    task automatic reportBadLine(input string text);
        $display("Input data file holds a line that is not a number: %s", text);
        abortRun();
    endtask

    // One clock and then every output checked against the model
    task automatic stepCycle();
        @(posedge pixelClock);
        #1;
        if (reset) begin
            blinkModel = '0;
            checkVideo(videoOut, '0);
            checkSample("toneSample", toneSample, 16'sd0);
            checkBit("deltaSigma", deltaSigma, 1'b0);
            checkBit("blink", blink, 1'b0);
        end else begin
            blinkModel = blinkModel + 1'b1;
            checkVideo(videoOut, expectedVideo(releasedEdges));
            checkBit("blink", blink, blinkModel[5]);
            if (releasedEdges == 0) begin
                checkBit("deltaSigma", deltaSigma, 1'b0);
            end
            // Bit at the strobe edge still belongs to the old sample
            if (windowOpen) begin
                if (deltaSigma) begin
                    onesCount++;
                end
                windowLength++;
            end
            if (sampleEnable) begin
                if (windowOpen) begin
                    checkDensity(onesCount, windowLength, windowTone);
                end
                toneIndex = toneIndex + 4'd1;
                expectedTone = expectedSamples[toneIndex];
                windowTone = expectedTone;
                windowOpen = 1'b1;
                onesCount = 0;
                windowLength = 0;
            end
            checkSample("toneSample", toneSample, expectedTone);
            releasedEdges++;
        end
    endtask

    // Strobe spacing wait with a guard against an oversized gap
    task automatic waitGap(input int cycles);
        int waited;
        waited = 0;
        while (waited < cycles && waited < gapLimit) begin
            stepCycle();
            waited++;
        end
        if (waited != cycles) begin
            $display("Timed out waiting %0d cycles for the next strobe", cycles);
            abortRun();
        end
    endtask

    initial begin
        int fd;
        string text;
        logic [23:0] colorWord;
        logic [15:0] sampleWord;
        int gap;
        int waited;
        pixelClock = 1'b0;
        reset = 1'b1;
        sampleEnable = 1'b0;
        releasedEdges = 0;
        blinkModel = '0;
        toneIndex = '0;
        windowOpen = 1'b0;
        onesCount = 0;
        windowLength = 0;
        windowTone = '0;
        void'($urandom(94));

        fd = $fopen("dv/avPatternsInput.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the input data file dv/avPatternsInput.txt");
            abortRun();
        end
        for (int i = 0; i < 8; i++) begin
            readDataLine(fd, text);
            if ($sscanf(text, "%h", colorWord) != 1) begin
                reportBadLine(text);
            end
            expectedColors[i] = colorWord;
        end
        for (int i = 0; i < 16; i++) begin
            readDataLine(fd, text);
            if ($sscanf(text, "%h", sampleWord) != 1) begin
                reportBadLine(text);
            end
            expectedSamples[i] = sampleWord;
        end
        readDataLine(fd, text);
        if ($sscanf(text, "%d", minGap) != 1) begin
            reportBadLine(text);
        end
        readDataLine(fd, text);
        if ($sscanf(text, "%d", maxGap) != 1) begin
            reportBadLine(text);
        end
        $fclose(fd);
        expectedTone = expectedSamples[0];

        // Reset for three cycles with all outputs idle
        repeat (3) begin
            stepCycle();
        end
        reset = 1'b0;

        // First active pixel shows up two edges after release
        waited = 0;
        while (videoOut.timing.dataEnable !== 1'b1 && waited < releaseTimeout) begin
            stepCycle();
            waited++;
        end
        if (videoOut.timing.dataEnable !== 1'b1) begin
            $display("Timed out waiting for active video after reset release");
            abortRun();
        end

        // Random strobe spacing where 20 strobes wrap the sine table
        for (int strobeIndex = 0; strobeIndex < strobeCount; strobeIndex++) begin
            gap = minGap + int'($urandom % (maxGap - minGap + 1));
            waitGap(gap);
            sampleEnable = 1'b1;
            stepCycle();
            sampleEnable = 1'b0;
        end

        if (releasedEdges < 2 * lineLength * frameLines + 1) begin
            $display("Run ended before two full frames were checked");
            abortRun();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== dv/avPatternsInput.txt ====
// Expected bar colours as 24-bit RRGGBB hex, then 16 sine samples as 16-bit hex,
// then the minimum and maximum strobe spacing in cycles as decimal
// Bar colours, left to right
C0C0C0
C0C000
00C0C0
00C000
C000C0
C00000
0000C0
000000
// Sine samples, one period
0000
187E
2D41
3B21
4000
3B21
2D41
187E
0000
E782
D2BF
C4DF
C000
C4DF
D2BF
E782
// Strobe spacing bounds
200
300

// ==== filelist.f ====
src/AvPatternPkg.sv
src/VideoFormatTiming.sv
src/ColorBarPattern.sv
src/SineTone.sv
src/AudioDeltaSigmaDac.sv
src/AvTestPatterns.sv
dv/AvTestPatterns_tb.sv

// ==== Bender.yml ====
package:
  name: av_test_patterns

sources:
  - src/AvPatternPkg.sv
  - src/VideoFormatTiming.sv
  - src/ColorBarPattern.sv
  - src/SineTone.sv
  - src/AudioDeltaSigmaDac.sv
  - src/AvTestPatterns.sv
  - target: test
    files:
      - dv/AvTestPatterns_tb.sv
